// ==== files.f ====
usb_rx_pkg.sv
rx_timer.sv
rx_decoder.sv
rx_deserializer.sv
crc_check.sv
rx_control_fsm.sv
usb_rx.sv
tb_clock.sv
tb_usb_rx.sv

// ==== Bender.yml ====
package:
  name: usb_rx

sources:
  - usb_rx_pkg.sv
  - rx_timer.sv
  - rx_decoder.sv
  - rx_deserializer.sv
  - crc_check.sv
  - rx_control_fsm.sv
  - usb_rx.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_usb_rx.sv

// ==== tb_usb_rx.sv ====
// testbench for the usb receive path; encodes packets onto d+/d- and checks results and bytes.
`timescale 1ns/1ps

module tb_usb_rx;
  import usb_rx_pkg::*;

  localparam int CLKS_PER_BIT = 8;
  localparam int TIMEOUT_CLKS = 100 * CLKS_PER_BIT;

  logic        clk;
  logic        n_rst;
  logic        d_plus;
  logic        d_minus;
  rx_pid_e     rx_packet;
  logic        store_rx_packet_data;
  data_byte_t  rx_packet_data;

  data_byte_t  body_q[$]; // bytes after the pid as sent.
  data_byte_t  got_q[$];
  logic [31:0] rng;
  logic        level;
  int          ones;
  int          eop_cnt;
  logic        saw_none;
  int          checks;
  int          errors;
  int          k;
  int          n;

  tb_clock clk_gen (
    .clk  (clk),
    .n_rst(n_rst)
  );

  usb_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) dut0 (
    .clk                 (clk),
    .n_rst               (n_rst),
    .d_plus              (d_plus),
    .d_minus             (d_minus),
    .rx_packet           (rx_packet),
    .store_rx_packet_data(store_rx_packet_data),
    .rx_packet_data      (rx_packet_data)
  );

  // collects strobed bytes, counts eop strobes, notes a return to RX_NONE.
  always @(posedge clk) begin
    if (store_rx_packet_data) begin
      got_q.push_back(rx_packet_data);
    end
    if (dut0.rx_bit.eop) begin
      eop_cnt = eop_cnt + 1;
    end
    if (rx_packet == RX_NONE) begin
      saw_none = 1'b1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // inverted reflected crc5 over the 11 token bits.
  function automatic logic [4:0] crc5_ref(input logic [10:0] data);
    logic [4:0] crc;
    logic       fb;
    int         i;
    crc = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb  = crc[0] ^ data[i];
      crc = crc >> 1;
      if (fb) begin
        crc = crc ^ 5'h14;
      end
    end
    return ~crc;
  endfunction

  // one byte of reflected crc16 with poly a001.
  function automatic logic [15:0] crc16_step(input logic [15:0] crc_in, input data_byte_t b);
    logic [15:0] crc;
    logic        fb;
    int          i;
    crc = crc_in;
    for (i = 0; i < 8; i++) begin
      fb  = crc[0] ^ b[i];
      crc = crc >> 1;
      if (fb) begin
        crc = crc ^ 16'ha001;
      end
    end
    return crc;
  endfunction

  function automatic rx_pid_e expected_result(input pid_t pid, input int len,
                                              input logic corrupt);
    if (corrupt) begin
      return RX_ERR;
    end
    case (pid)
      PID_OUT:   return (len == 2) ? RX_OUT : RX_ERR;
      PID_IN:    return (len == 2) ? RX_IN : RX_ERR;
      PID_DATA0: return (len >= 2) ? RX_DATA0 : RX_ERR;
      PID_DATA1: return (len >= 2) ? RX_DATA1 : RX_ERR;
      PID_ACK:   return (len == 0) ? RX_ACK : RX_ERR;
      PID_NAK:   return (len == 0) ? RX_NAK : RX_ERR;
      default:   return RX_ERR;
    endcase
  endfunction

  task automatic drive_line(input logic dp, input logic dm);
    @(posedge clk);
    d_plus  <= dp;
    d_minus <= dm;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // nrzi with a stuffed zero after six ones.
  task automatic send_bit(input logic b);
    if (!b) begin
      level = !level;
      ones  = 0;
    end else begin
      ones = ones + 1;
    end
    drive_line(level, !level);
    if (ones == 6) begin
      level = !level;
      ones  = 0;
      drive_line(level, !level);
    end
  endtask

  task automatic send_byte(input data_byte_t b);
    int i;
    for (i = 0; i < 8; i++) begin
      send_bit(b[i]);
    end
  endtask

  task automatic send_packet(input pid_t pid, input pid_t chk);
    level = 1'b1;
    ones  = 0;
    drive_line(1'b1, 1'b0);
    drive_line(1'b1, 1'b0);
    send_byte(8'h80); // sync pattern kjkjkjkk.
    send_byte({chk, pid});
    foreach (body_q[i]) begin
      send_byte(body_q[i]);
    end
    drive_line(1'b0, 1'b0);
    drive_line(1'b0, 1'b0);
    drive_line(1'b1, 1'b0);
  endtask

  task automatic make_token();
    logic [10:0] tok;
    logic [15:0] word;
    rng  = xorshift(rng);
    tok  = rng[10:0]; // endpoint and address.
    word = {crc5_ref(tok), tok};
    body_q.delete();
    body_q.push_back(word[7:0]);
    body_q.push_back(word[15:8]);
  endtask

  task automatic make_data(input int len, input logic all_ones);
    logic [15:0] crc;
    data_byte_t  b;
    int          i;
    crc = 16'hffff;
    body_q.delete();
    for (i = 0; i < len; i++) begin
      rng = xorshift(rng);
      b   = all_ones ? 8'hff : rng[7:0];
      body_q.push_back(b);
      crc = crc16_step(crc, b);
    end
    crc = ~crc;
    body_q.push_back(crc[7:0]);
    body_q.push_back(crc[15:8]);
  endtask

  task automatic run_packet(input string name, input pid_t pid, input logic bad_pid,
                            input logic bad_crc);
    data_byte_t exp_q[$];
    rx_pid_e    exp;
    pid_t       chk;
    int         start;
    int         cnt;
    int         i;
    if (bad_crc) begin
      body_q[body_q.size() - 1] = body_q[body_q.size() - 1] ^ 8'h80; // top crc bit.
    end
    chk = bad_pid ? (~pid ^ 4'h1) : ~pid;
    got_q.delete();
    saw_none = 1'b0;
    start    = eop_cnt;
    send_packet(pid, chk);
    @(negedge clk);
    cnt = 0;
    while (eop_cnt == start && cnt < TIMEOUT_CLKS) begin
      @(negedge clk);
      cnt++;
    end
    if (eop_cnt == start) begin
      $display("timeout: %s saw no end of packet within 100 bit times", name);
      $display("Simulation failed");
      $finish;
    end
    exp = expected_result(pid, body_q.size(), bad_pid || bad_crc);
    if (!bad_pid && (pid == PID_DATA0 || pid == PID_DATA1)) begin
      exp_q = body_q;
    end
    checks = checks + 3;
    if (rx_packet !== exp) begin
      errors++;
      $display("error %s result: expected %s, actual %s", name, exp.name(), rx_packet.name());
    end
    if (!saw_none) begin
      errors++;
      $display("%s: rx_packet did not return to RX_NONE at sync", name);
    end
    if (got_q.size() != exp_q.size()) begin
      errors++;
      $display("error %s byte count: expected %0d, actual %0d", name, exp_q.size(),
               got_q.size());
    end else begin
      for (i = 0; i < exp_q.size(); i++) begin
        if (got_q[i] !== exp_q[i]) begin
          errors++;
          $display("error %s byte %0d: expected %h, actual %h", name, i, exp_q[i], got_q[i]);
        end
      end
    end
  endtask

  initial begin
    d_plus   = 1'b1; // idle j.
    d_minus  = 1'b0;
    rng      = 32'hd6ed;
    level    = 1'b1;
    ones     = 0;
    eop_cnt  = 0;
    saw_none = 1'b0;
    checks   = 0;
    errors   = 0;
    n        = 0;
    while (!n_rst && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!n_rst) begin
      $display("reset was never released");
      $display("Simulation failed");
      $finish;
    end
    repeat (20) drive_line(1'b1, 1'b0);
    @(negedge clk);
    checks = checks + 2;
    if (rx_packet !== RX_NONE) begin
      errors++;
      $display("error idle result: expected %s, actual %s", "RX_NONE", rx_packet.name());
    end
    if (got_q.size() != 0) begin
      errors++;
      $display("error idle strobes: expected 0, actual %0d", got_q.size());
    end
    for (k = 0; k < 4; k++) begin
      make_token();
      run_packet("token", k[0] ? PID_IN : PID_OUT, 1'b0, 1'b0);
    end
    for (k = 0; k < 8; k++) begin
      rng = xorshift(rng);
      make_data(int'(rng % 32'd9), 1'b0);
      run_packet("data", k[0] ? PID_DATA1 : PID_DATA0, 1'b0, 1'b0);
    end
    make_data(8, 1'b1);
    run_packet("stuffed data0", PID_DATA0, 1'b0, 1'b0);
    make_data(3, 1'b1);
    run_packet("stuffed data1", PID_DATA1, 1'b0, 1'b0);
    make_token();
    run_packet("token bad crc", PID_OUT, 1'b0, 1'b1);
    make_data(4, 1'b0);
    run_packet("data bad crc", PID_DATA1, 1'b0, 1'b1);
    make_token();
    run_packet("bad pid", PID_IN, 1'b1, 1'b0);
    body_q.delete();
    run_packet("ack", PID_ACK, 1'b0, 1'b0);
    body_q.delete();
    run_packet("nak", PID_NAK, 1'b0, 1'b0);
    make_token();
    run_packet("token after nak", PID_OUT, 1'b0, 1'b0);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
// testbench clock and reset source for the usb receive testbench; 8 ns clock, reset low 3 cycles.
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic n_rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    n_rst = 1'b0;
    repeat (3) @(posedge clk);
    n_rst <= 1'b1;
  end

endmodule

// ==== usb_rx.sv ====
// usb full-speed receiver top; takes the raw d+/d- pair and reports packet type and data bytes.
`timescale 1ns/1ps

module usb_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic                   clk,
  input  logic                   n_rst,
  input  logic                   d_plus,
  input  logic                   d_minus,
  output usb_rx_pkg::rx_pid_e    rx_packet,
  output logic                   store_rx_packet_data,
  output usb_rx_pkg::data_byte_t rx_packet_data
);
  import usb_rx_pkg::*;

  logic     sample;
  logic     line_dp;
  logic     line_dm;
  rx_bit_t  rx_bit;
  sr_word_t sr_data;
  logic     byte_done;
  logic     clear_count;
  logic     clear_crc;
  logic     crc_shift;
  logic     pass_5;
  logic     pass_16;

  assign crc_shift = rx_bit.bit_valid && !rx_bit.eop;

  rx_timer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_timer (
    .clk    (clk),
    .n_rst  (n_rst),
    .d_plus (d_plus),
    .d_minus(d_minus),
    .sample (sample),
    .line_dp(line_dp),
    .line_dm(line_dm)
  );

  rx_decoder u_decoder (
    .clk    (clk),
    .n_rst  (n_rst),
    .sample (sample),
    .line_dp(line_dp),
    .line_dm(line_dm),
    .rx_bit (rx_bit)
  );

  rx_deserializer u_deser (
    .clk        (clk),
    .n_rst      (n_rst),
    .rx_bit     (rx_bit),
    .clear_count(clear_count),
    .sr_data    (sr_data),
    .byte_done  (byte_done)
  );

  crc_check #(
    .WIDTH  (5),
    .POLY   (CRC5_POLY),
    .RESIDUE(CRC5_RESIDUE)
  ) u_crc5 (
    .clk     (clk),
    .n_rst   (n_rst),
    .clear   (clear_crc),
    .shift_en(crc_shift),
    .bit_in  (rx_bit.bit_val),
    .pass    (pass_5)
  );

  crc_check #(
    .WIDTH  (16),
    .POLY   (CRC16_POLY),
    .RESIDUE(CRC16_RESIDUE)
  ) u_crc16 (
    .clk     (clk),
    .n_rst   (n_rst),
    .clear   (clear_crc),
    .shift_en(crc_shift),
    .bit_in  (rx_bit.bit_val),
    .pass    (pass_16)
  );

  rx_control_fsm u_fsm (
    .clk                 (clk),
    .n_rst               (n_rst),
    .rx_bit              (rx_bit),
    .sr_data             (sr_data),
    .byte_done           (byte_done),
    .pass_5              (pass_5),
    .pass_16             (pass_16),
    .clear_crc           (clear_crc),
    .clear_count         (clear_count),
    .rx_packet           (rx_packet),
    .store_rx_packet_data(store_rx_packet_data),
    .rx_packet_data      (rx_packet_data)
  );

endmodule

// ==== rx_control_fsm.sv ====
// packet fsm: finds sync, checks the pid, tracks the packet body and reports the result.
`timescale 1ns/1ps

module rx_control_fsm (
  input  logic                   clk,
  input  logic                   n_rst,
  input  usb_rx_pkg::rx_bit_t    rx_bit,
  input  usb_rx_pkg::sr_word_t   sr_data,
  input  logic                   byte_done,
  input  logic                   pass_5,
  input  logic                   pass_16,
  output logic                   clear_crc,
  output logic                   clear_count,
  output usb_rx_pkg::rx_pid_e    rx_packet,
  output logic                   store_rx_packet_data,
  output usb_rx_pkg::data_byte_t rx_packet_data
);
  import usb_rx_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    PID,
    TOKEN,
    DATA,
    HANDSHAKE,
    WAIT_EOP
  } state_e;

  state_e     state_q;
  state_e     state_d;
  rx_pid_e    rx_packet_d;
  pid_t       pid_q;
  pid_t       pid_d;
  logic [1:0] byte_cnt_q; // bytes after the pid, saturating.
  logic [1:0] byte_cnt_d;
  logic       mid_byte_q;
  logic       mid_byte_d;
  logic       clear_count_d;
  logic       store_d;
  data_byte_t cur_byte;
  pid_t       rx_pid;
  pid_t       rx_pid_chk;
  logic       sync_seen;

  assign cur_byte   = sr_data[15:8];
  assign rx_pid     = cur_byte[3:0];
  assign rx_pid_chk = cur_byte[7:4];
  assign sync_seen  = rx_bit.bit_valid && (cur_byte == SYNC_PATTERN);

  always_comb begin
    state_d       = state_q;
    rx_packet_d   = rx_packet;
    pid_d         = pid_q;
    byte_cnt_d    = byte_cnt_q;
    mid_byte_d    = mid_byte_q;
    clear_count_d = 1'b0;
    store_d       = 1'b0;
    if (rx_bit.bit_valid) begin
      mid_byte_d = !byte_done;
    end
    if (byte_done && byte_cnt_q != 2'd3) begin
      byte_cnt_d = byte_cnt_q + 2'd1;
    end
    unique case (state_q)
      IDLE: begin
        if (sync_seen) begin
          state_d       = PID;
          rx_packet_d   = RX_NONE;
          clear_count_d = 1'b1;
          byte_cnt_d    = '0;
          mid_byte_d    = 1'b0;
        end
      end
      PID: begin
        if (rx_bit.eop) begin
          state_d     = IDLE;
          rx_packet_d = RX_ERR;
        end else if (byte_done) begin
          pid_d      = rx_pid;
          byte_cnt_d = '0;
          if (rx_pid_chk != ~rx_pid) begin
            state_d     = WAIT_EOP;
            rx_packet_d = RX_ERR;
          end else begin
            unique case (rx_pid)
              PID_OUT, PID_IN:     state_d = TOKEN;
              PID_DATA0, PID_DATA1: state_d = DATA;
              PID_ACK, PID_NAK:    state_d = HANDSHAKE;
              default: begin
                state_d     = WAIT_EOP; // setup, sof and the rest.
                rx_packet_d = RX_ERR;
              end
            endcase
          end
        end
      end
      TOKEN: begin
        if (rx_bit.eop) begin
          state_d     = IDLE;
          rx_packet_d = RX_ERR;
          if (pass_5 && byte_cnt_q == 2'd2 && !mid_byte_q) begin
            rx_packet_d = (pid_q == PID_OUT) ? RX_OUT : RX_IN;
          end
        end
      end
      DATA: begin
        if (rx_bit.eop) begin
          state_d     = IDLE;
          rx_packet_d = RX_ERR;
          if (pass_16 && byte_cnt_q >= 2'd2 && !mid_byte_q) begin
            rx_packet_d = (pid_q == PID_DATA0) ? RX_DATA0 : RX_DATA1;
          end
        end else if (byte_done) begin
          store_d = 1'b1;
        end
      end
      HANDSHAKE: begin
        if (rx_bit.eop) begin
          state_d     = IDLE;
          rx_packet_d = RX_ERR;
          if (byte_cnt_q == 2'd0 && !mid_byte_q) begin
            rx_packet_d = (pid_q == PID_ACK) ? RX_ACK : RX_NAK;
          end
        end
      end
      WAIT_EOP: begin
        if (rx_bit.eop) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      state_q              <= IDLE;
      rx_packet            <= RX_NONE;
      pid_q                <= '0;
      byte_cnt_q           <= '0;
      mid_byte_q           <= 1'b0;
      clear_count          <= 1'b0;
      clear_crc            <= 1'b0;
      store_rx_packet_data <= 1'b0;
    end else begin
      state_q              <= state_d;
      rx_packet            <= rx_packet_d;
      pid_q                <= pid_d;
      byte_cnt_q           <= byte_cnt_d;
      mid_byte_q           <= mid_byte_d;
      clear_count          <= clear_count_d;
      clear_crc            <= (state_d == PID); // held through the pid byte.
      store_rx_packet_data <= store_d;
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) begin
      rx_packet_data <= cur_byte;
    end
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    store_rx_packet_data |-> (state_q == DATA) && $past(byte_done));

endmodule

// ==== crc_check.sv ====
// serial crc register with residue compare; instantiated once for crc5 and once for crc16.
`timescale 1ns/1ps

module crc_check #(
  parameter int               WIDTH   = 5,
  parameter logic [WIDTH-1:0] POLY    = '0,
  parameter logic [WIDTH-1:0] RESIDUE = '0
) (
  input  logic clk,
  input  logic n_rst,
  input  logic clear,
  input  logic shift_en,
  input  logic bit_in,
  output logic pass
);

  logic [WIDTH-1:0] crc;
  logic             feedback;

  assign feedback = bit_in ^ crc[WIDTH-1];
  assign pass     = (crc == RESIDUE);

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      crc <= '1;
    end else if (clear) begin
      crc <= '1;
    end else if (shift_en) begin
      if (feedback) begin
        crc <= {crc[WIDTH-2:0], 1'b0} ^ POLY;
      end else begin
        crc <= {crc[WIDTH-2:0], 1'b0};
      end
    end
  end

endmodule

// ==== rx_deserializer.sv ====
// shift register and bit counter that turn the decoded bit stream into bytes for the control fsm.
`timescale 1ns/1ps

module rx_deserializer (
  input  logic                 clk,
  input  logic                 n_rst,
  input  usb_rx_pkg::rx_bit_t  rx_bit,
  input  logic                 clear_count,
  output usb_rx_pkg::sr_word_t sr_data,
  output logic                 byte_done
);
  import usb_rx_pkg::*;

  sr_word_t   sr_q;
  logic [2:0] bit_cnt;

  // window including the bit arriving this cycle.
  assign sr_data   = rx_bit.bit_valid ? {rx_bit.bit_val, sr_q[15:1]} : sr_q;
  assign byte_done = rx_bit.bit_valid && (bit_cnt == 3'd7);

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      sr_q    <= '1;
      bit_cnt <= '0;
    end else begin
      if (rx_bit.eop) begin
        sr_q <= '1; // flush so stale bits never look like sync.
      end else if (rx_bit.bit_valid) begin
        sr_q <= sr_data;
      end
      if (clear_count) begin
        bit_cnt <= '0;
      end else if (rx_bit.bit_valid) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!n_rst) byte_done |-> rx_bit.bit_valid);

endmodule

// ==== rx_decoder.sv ====
// nrzi decoder with stuffed-bit removal and eop detection, driven by the timer sample strobe.
`timescale 1ns/1ps

module rx_decoder (
  input  logic                clk,
  input  logic                n_rst,
  input  logic                sample,
  input  logic                line_dp,
  input  logic                line_dm,
  output usb_rx_pkg::rx_bit_t rx_bit
);
  import usb_rx_pkg::*;

  localparam logic [2:0] ONES_STUFF = 3'd6;
  localparam logic [2:0] ONES_IDLE  = 3'd7;

  logic       prev_dp;
  logic [2:0] ones_cnt;
  logic [1:0] se0_cnt;
  logic       se0;
  logic       same;
  logic       stuffed;
  rx_bit_t    rx_bit_d;

  assign se0     = !line_dp && !line_dm;
  assign same    = (line_dp == prev_dp);
  assign stuffed = !same && (ones_cnt == ONES_STUFF);

  always_comb begin
    rx_bit_d = '0;
    rx_bit_d.bit_val = same;
    if (sample) begin
      if (se0) begin
        rx_bit_d.eop = (se0_cnt == 2'd1); // second se0 sample.
      end else if (se0_cnt == 2'd0 && !stuffed) begin
        rx_bit_d.bit_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      prev_dp  <= 1'b1;
      ones_cnt <= ONES_IDLE;
      se0_cnt  <= '0;
      rx_bit   <= '0;
    end else begin
      rx_bit <= rx_bit_d;
      if (sample) begin
        prev_dp <= line_dp;
        if (se0) begin
          if (se0_cnt != 2'd2) begin
            se0_cnt <= se0_cnt + 2'd1;
          end
          if (se0_cnt == 2'd1) begin
            ones_cnt <= ONES_IDLE; // back to idle after eop.
          end
        end else begin
          se0_cnt <= '0;
          // the j after se0 carries no data.
          if (se0_cnt == 2'd0) begin
            if (!same) begin
              ones_cnt <= '0;
            end else if (ones_cnt != ONES_IDLE) begin
              ones_cnt <= ones_cnt + 3'd1;
            end
          end
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!n_rst)
    !(rx_bit.bit_valid && rx_bit.eop));

endmodule

// ==== rx_timer.sv ====
// line synchronizer and bit clock recovery; pulses sample near the middle of each bit time.
`timescale 1ns/1ps

module rx_timer #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic n_rst,
  input  logic d_plus,
  input  logic d_minus,
  output logic sample,
  output logic line_dp,
  output logic line_dm
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_M1 = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

  logic meta_dp;
  logic meta_dm;
  logic dp_prev;
  logic edge_seen;
  logic [CNT_W-1:0] phase;

  assign edge_seen = (line_dp != dp_prev);

  always_ff @(posedge clk or negedge n_rst) begin
    if (!n_rst) begin
      meta_dp <= 1'b1; // idle j.
      meta_dm <= 1'b0;
      line_dp <= 1'b1;
      line_dm <= 1'b0;
      dp_prev <= 1'b1;
      phase   <= '0;
      sample  <= 1'b0;
    end else begin
      meta_dp <= d_plus;
      meta_dm <= d_minus;
      line_dp <= meta_dp;
      line_dm <= meta_dm;
      dp_prev <= line_dp;
      sample  <= !edge_seen && (phase == HALF_M1);
      if (edge_seen) begin
        phase <= CNT_W'(1); // realign on every transition.
      end else if (phase == LAST) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!n_rst) sample |=> !sample);

endmodule

// ==== usb_rx_pkg.sv ====
// shared types and constants for the usb full-speed receive path, imported by each rx block.
package usb_rx_pkg;

  typedef logic [7:0]  data_byte_t;
  typedef logic [3:0]  pid_t;
  typedef logic [15:0] sr_word_t;

  // decoded bit stream from the line decoder.
  typedef struct packed {
    logic bit_valid;
    logic bit_val;
    logic eop;
  } rx_bit_t;

  typedef enum logic [2:0] {
    RX_NONE,
    RX_OUT,
    RX_IN,
    RX_DATA0,
    RX_DATA1,
    RX_ACK,
    RX_NAK,
    RX_ERR
  } rx_pid_e;

  localparam pid_t PID_OUT   = 4'b0001;
  localparam pid_t PID_IN    = 4'b1001;
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;

  localparam logic [4:0]  CRC5_POLY     = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b01100;
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUE = 16'h800d;

  // kjkjkjkk decodes to seven zeros then a one, lsb first.
  localparam data_byte_t SYNC_PATTERN = 8'h80;

endpackage
